// ==== ofdm_tx_pkg.sv ====
// 802.11a transmitter front end shared definitions
// Frame constants, the legacy rate table and the L-SIG word layout

`default_nettype none

package ofdm_tx_pkg;

    localparam int MEM_ADDR_W   = 12;
    localparam int MEM_DATA_W   = 64;
    localparam int SIG_BITS     = 24;
    localparam int SERVICE_BITS = 16;
    localparam int TAIL_BITS    = 6;
    localparam int FCS_BITS     = 32;
    localparam int SCRAM_W      = 7;
    localparam int DBPS_W       = 9;
    localparam int LEN_W        = 12;
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

    // Convolutional code, K=7, generators in octal
    localparam int ENC_K = 7;
    localparam logic [ENC_K-1:0] ENC_G0 = 7'o133;
    localparam logic [ENC_K-1:0] ENC_G1 = 7'o171;

    // Field sequencer states
    localparam logic [2:0] FLD_SIG     = 3'd0;
    localparam logic [2:0] FLD_SERVICE = 3'd1;
    localparam logic [2:0] FLD_PSDU    = 3'd2;
    localparam logic [2:0] FLD_FCS     = 3'd3;
    localparam logic [2:0] FLD_TAIL    = 3'd4;
    localparam logic [2:0] FLD_PAD     = 3'd5;

    // L-SIG word, sent as raw bits and decoded as fields
    typedef union packed {
        logic [SIG_BITS-1:0] raw;
        struct packed {
            logic [5:0]       tail;
            logic             parity;
            logic [LEN_W-1:0] length;
            logic             reserved;
            logic [3:0]       rate;
        } f;
    } l_sig_u;

    // Data bits per OFDM symbol, unknown codes fall back to 6 Mbps
    function automatic logic [DBPS_W-1:0] n_dbps_of_rate(input logic [3:0] rate);
        case (rate)
            4'b1011: return 9'd24;
            4'b1111: return 9'd36;
            4'b1010: return 9'd48;
            4'b1110: return 9'd72;
            4'b1001: return 9'd96;
            4'b1101: return 9'd144;
            4'b1000: return 9'd192;
            4'b1100: return 9'd216;
            default: return 9'd24;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== ofdm_tx_if.sv ====
// Internal streams of the transmitter
// tx_bit_if carries uncoded frame bits, coded_if carries bit pairs

`timescale 1ns/1ps
`default_nettype none

interface tx_bit_if;
    logic data;
    logic valid;
    logic ready;
    logic is_sig;
    logic last;

    modport src (output data, valid, is_sig, last, input ready);
    modport snk (input data, valid, is_sig, last, output ready);
endinterface

interface coded_if;
    logic [1:0] pair;
    logic       valid;
    logic       ready;
    logic       flush;
    logic       last;

    modport src (output pair, valid, flush, last, input ready);
    modport snk (input pair, valid, flush, last, output ready);
endinterface

`default_nettype wire

// ==== frame_fetch.sv ====
// Frame fetch
// Reads L-SIG and PSDU words from frame memory and serializes them,
// L-SIG first, then the PSDU from word 1 onward, LSB first

`timescale 1ns/1ps
`default_nettype none

module frame_fetch
    import ofdm_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic                  i_start,
    input  logic                  i_done,
    input  logic [MEM_DATA_W-1:0] i_mem_rdata,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    output logic                  o_busy,
    output l_sig_u                o_sig,
    tx_bit_if.src                 bits_out
);

    logic                  busy_q;
    logic                  sig_vld;
    logic                  rd_pend;
    logic                  rd_fire;
    logic                  rd_done;
    logic                  last_rd;
    logic                  pre_vld;
    logic [MEM_DATA_W-1:0] pre_q;
    logic [MEM_DATA_W-1:0] word_q;
    logic                  word_vld;
    logic [5:0]            bit_idx;
    logic [4:0]            sig_left;
    logic [LEN_W+2:0]      psdu_left;
    logic [MEM_ADDR_W-1:0] last_addr;
    l_sig_u                rd_sig;
    logic                  in_sig;
    logic                  xfer;
    logic                  psdu_xfer;
    logic                  word_end;
    logic                  load;

    assign rd_sig = i_mem_rdata[SIG_BITS-1:0];

    // Last word holding PSDU bits, FCS bytes are not in memory
    assign last_addr = MEM_ADDR_W'(({1'b0, o_sig.f.length} + 13'd3) >> 3);

    // Memory samples o_mem_addr every cycle, data follows one cycle later
    assign last_rd = sig_vld && o_mem_addr == last_addr;
    assign rd_fire = busy_q && !rd_pend && !pre_vld && !rd_done &&
                     (sig_vld || o_mem_addr == '0);

    assign o_busy = busy_q && !i_done;

    ////////////////////////////////////////
    // Bit stream
    ////////////////////////////////////////
    assign in_sig          = sig_left != '0;
    assign bits_out.valid  = in_sig ? sig_vld : word_vld;
    assign bits_out.data   = in_sig ? o_sig.raw[5'(SIG_BITS) - sig_left] : word_q[bit_idx];
    assign bits_out.is_sig = in_sig;
    assign bits_out.last   = !in_sig && psdu_left == 15'd1;

    assign xfer      = bits_out.valid && bits_out.ready;
    assign psdu_xfer = xfer && !in_sig;
    assign word_end  = bit_idx == 6'd63 || psdu_left == 15'd1;
    // Next word moves in as soon as the current one drains
    assign load      = pre_vld && (!word_vld || (psdu_xfer && word_end));

    always_ff @(posedge clk) begin
        if (reset_int) begin
            busy_q     <= 1'b0;
            sig_vld    <= 1'b0;
            rd_pend    <= 1'b0;
            rd_done    <= 1'b0;
            pre_vld    <= 1'b0;
            word_vld   <= 1'b0;
            o_mem_addr <= '0;
            bit_idx    <= '0;
            sig_left   <= '0;
            psdu_left  <= '0;
        end else if (i_start && !busy_q) begin
            busy_q     <= 1'b1;
            sig_vld    <= 1'b0;
            rd_pend    <= 1'b0;
            rd_done    <= 1'b0;
            pre_vld    <= 1'b0;
            word_vld   <= 1'b0;
            o_mem_addr <= '0;
            bit_idx    <= '0;
            sig_left   <= 5'(SIG_BITS);
            psdu_left  <= '0;
        end else begin
            if (i_done) begin
                busy_q <= 1'b0;
            end
            rd_pend <= rd_fire;
            // Address parks on the last PSDU word once it is read
            if (rd_fire) begin
                if (last_rd) begin
                    rd_done <= 1'b1;
                end else begin
                    o_mem_addr <= o_mem_addr + 1'b1;
                end
            end
            // Word 0 is the L-SIG word, later words go to the prefetch slot
            if (rd_pend && !sig_vld) begin
                sig_vld   <= 1'b1;
                psdu_left <= {rd_sig.f.length, 3'b000} - 15'(FCS_BITS);
            end else if (psdu_xfer) begin
                psdu_left <= psdu_left - 1'b1;
            end
            if (rd_pend && sig_vld) begin
                pre_vld <= 1'b1;
            end else if (load) begin
                pre_vld <= 1'b0;
            end
            if (load) begin
                word_vld <= 1'b1;
                bit_idx  <= '0;
            end else if (psdu_xfer) begin
                bit_idx <= bit_idx + 1'b1;
                if (word_end) begin
                    word_vld <= 1'b0;
                end
            end
            if (xfer && in_sig) begin
                sig_left <= sig_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend && !sig_vld) begin
            o_sig <= rd_sig;
        end
        if (rd_pend) begin
            pre_q <= i_mem_rdata;
        end
        if (load) begin
            word_q <= pre_q;
        end
    end

    // Reads stop at the last word the L-SIG length needs
    a_addr_bound: assert property (@(posedge clk) disable iff (reset_int)
        sig_vld |-> o_mem_addr <= last_addr)
        else $error("frame_fetch read past last PSDU word");

endmodule

`default_nettype wire

// ==== crc32_fcs.sv ====
// Bit-serial CRC-32 for the frame check sequence
// Reflected IEEE polynomial, the FCS leaves complemented, x^31 first

`timescale 1ns/1ps
`default_nettype none

module crc32_fcs (
    input  logic clk,
    input  logic reset_int,
    input  logic i_init,
    input  logic i_data_en,
    input  logic i_bit,
    input  logic i_shift_en,
    output logic o_fcs_bit
);

    logic [31:0] crc;
    logic        fb;

    assign fb        = crc[0] ^ i_bit;
    // Reflected register keeps the x^31 coefficient in bit 0
    assign o_fcs_bit = ~crc[0];

    always_ff @(posedge clk) begin
        if (reset_int || i_init) begin
            crc <= '1;
        end else if (i_data_en) begin
            crc <= (crc >> 1) ^ (fb ? 32'hEDB8_8320 : 32'h0);
        end else if (i_shift_en) begin
            crc <= {1'b1, crc[31:1]};
        end
    end

endmodule

`default_nettype wire

// ==== tx_bit_sequencer.sv ====
// DATA field builder
// Passes L-SIG through, adds SERVICE, FCS, tail and pad around the PSDU
// and scrambles the DATA bits

`timescale 1ns/1ps
`default_nettype none

module tx_bit_sequencer
    import ofdm_tx_pkg::*;
(
    input  logic               clk,
    input  logic               reset_int,
    input  logic [SCRAM_W-1:0] i_scram_seed,
    input  l_sig_u             i_sig,
    tx_bit_if.snk              bits_in,
    coded_if.src               bits_out
);

    logic [2:0]         fld;
    logic [2:0]         fld_nxt;
    logic [4:0]         cnt;
    logic [DBPS_W-1:0]  dbps_cnt;
    logic [DBPS_W-1:0]  n_dbps;
    logic [SCRAM_W-1:0] scram;
    logic               scram_fb;
    logic               raw_bit;
    logic               out_bit;
    logic               pass;
    logic               xfer;
    logic               fld_end;
    logic               sym_end;
    logic               fcs_bit;

    assign n_dbps   = n_dbps_of_rate(i_sig.f.rate);
    assign scram_fb = scram[6] ^ scram[3];
    assign sym_end  = dbps_cnt == n_dbps - 1'b1;

    ////////////////////////////////////////
    // Field select
    ////////////////////////////////////////
    always_comb begin
        raw_bit = 1'b0;
        fld_end = 1'b0;
        fld_nxt = fld;
        case (fld)
            FLD_SIG: begin
                raw_bit = bits_in.data;
                fld_end = cnt == 5'(SIG_BITS - 1);
                fld_nxt = FLD_SERVICE;
            end
            FLD_SERVICE: begin
                fld_end = cnt == 5'(SERVICE_BITS - 1);
                fld_nxt = FLD_PSDU;
            end
            FLD_PSDU: begin
                raw_bit = bits_in.data;
                fld_end = bits_in.last;
                fld_nxt = FLD_FCS;
            end
            FLD_FCS: begin
                raw_bit = fcs_bit;
                fld_end = cnt == 5'(FCS_BITS - 1);
                fld_nxt = FLD_TAIL;
            end
            FLD_TAIL: begin
                fld_end = cnt == 5'(TAIL_BITS - 1);
                // No pad when the tail closes a symbol
                fld_nxt = sym_end ? FLD_SIG : FLD_PAD;
            end
            default: begin
                fld_end = sym_end;
                fld_nxt = FLD_SIG;
            end
        endcase
    end

    // L-SIG and tail go out unscrambled
    assign out_bit = (fld == FLD_SIG || fld == FLD_TAIL) ? raw_bit : raw_bit ^ scram_fb;
    assign pass    = fld == FLD_SIG || fld == FLD_PSDU;

    assign bits_in.ready  = pass && bits_out.ready;
    assign bits_out.valid = pass ? bits_in.valid : 1'b1;
    assign bits_out.pair  = {1'b0, out_bit};
    assign bits_out.flush = cnt == '0 &&
                            ((fld == FLD_SIG && bits_in.is_sig) || fld == FLD_SERVICE);
    assign bits_out.last  = fld_end && fld_nxt == FLD_SIG && fld != FLD_SIG;

    assign xfer = bits_out.valid && bits_out.ready;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            fld      <= FLD_SIG;
            cnt      <= '0;
            dbps_cnt <= '0;
            scram    <= '0;
        end else if (xfer) begin
            cnt <= fld_end ? '0 : cnt + 1'b1;
            if (fld_end) begin
                fld <= fld_nxt;
            end
            if (fld == FLD_SIG) begin
                if (fld_end) begin
                    scram    <= i_scram_seed;
                    dbps_cnt <= '0;
                end
            end else begin
                // Scrambler steps on every DATA bit, tail included
                scram    <= {scram[SCRAM_W-2:0], scram_fb};
                dbps_cnt <= sym_end ? '0 : dbps_cnt + 1'b1;
            end
        end
    end

    crc32_fcs u_crc (
        .clk        (clk),
        .reset_int  (reset_int),
        .i_init     (fld == FLD_SERVICE),
        .i_data_en  (xfer && fld == FLD_PSDU),
        .i_bit      (bits_in.data),
        .i_shift_en (xfer && fld == FLD_FCS),
        .o_fcs_bit  (fcs_bit)
    );

    // An all-zero seed would leave DATA unscrambled
    a_seed_nonzero: assert property (@(posedge clk) disable iff (reset_int)
        (xfer && fld == FLD_SIG && fld_end) |-> i_scram_seed != '0)
        else $error("scrambler seed is zero at SERVICE");

endmodule

`default_nettype wire

// ==== conv_encoder.sv ====
// Rate-1/2 K=7 convolutional encoder
// One registered pair in flight, the register restarts from zero on flush

`timescale 1ns/1ps
`default_nettype none

module conv_encoder
    import ofdm_tx_pkg::*;
(
    input  logic clk,
    input  logic reset_int,
    coded_if.snk bits_in,
    coded_if.src pairs_out
);

    logic [ENC_K-2:0] sr;
    logic [ENC_K-2:0] sr_eff;
    logic [ENC_K-1:0] taps;
    logic             in_xfer;
    logic             out_vld;
    logic [1:0]       out_pair;
    logic             out_last;

    assign bits_in.ready = !out_vld || pairs_out.ready;
    assign in_xfer       = bits_in.valid && bits_in.ready;

    // Newest bit on the left, six past bits to the right
    assign sr_eff = bits_in.flush ? '0 : sr;
    assign taps   = {bits_in.pair[0], sr_eff};

    always_ff @(posedge clk) begin
        if (reset_int) begin
            sr      <= '0;
            out_vld <= 1'b0;
        end else if (in_xfer) begin
            sr      <= taps[ENC_K-1:1];
            out_vld <= 1'b1;
        end else if (pairs_out.ready) begin
            out_vld <= 1'b0;
        end
    end

    // A from G0 in bit 0, B from G1 in bit 1
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            out_pair <= {^(taps & ENC_G1), ^(taps & ENC_G0)};
            out_last <= bits_in.last;
        end
    end

    assign pairs_out.valid = out_vld;
    assign pairs_out.pair  = out_pair;
    assign pairs_out.last  = out_last;
    assign pairs_out.flush = 1'b0;

endmodule

`default_nettype wire

// ==== coded_bit_fifo.sv ====
// Coded pair output FIFO
// Drives the valid/ready output stream and pulses done after the last pair

`timescale 1ns/1ps
`default_nettype none

module coded_bit_fifo
    import ofdm_tx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_int,
    input  logic       i_coded_ready,
    coded_if.snk       pairs_in,
    output logic       o_coded_valid,
    output logic [1:0] o_coded_bits,
    output logic       o_done
);

    // Each entry holds {last, pair}
    logic [2:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic [2:0]       head;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    assign empty = wr_ptr == rd_ptr;
    assign full  = wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW] &&
                   wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0];

    assign pairs_in.ready = !full;
    assign wr_en          = pairs_in.valid && !full;
    assign rd_en          = o_coded_valid && i_coded_ready;

    assign head          = mem[rd_ptr[FIFO_AW-1:0]];
    assign o_coded_valid = !empty;
    assign o_coded_bits  = head[1:0];

    always_ff @(posedge clk) begin
        if (reset_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_done <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_done <= rd_en && head[2];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= {pairs_in.last, pairs_in.pair};
        end
    end

    // Pointers stay put while the FIFO is full or empty
    a_no_overflow: assert property (@(posedge clk) disable iff (reset_int)
        full |=> wr_ptr == $past(wr_ptr))
        else $error("coded_bit_fifo write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset_int)
        empty |=> rd_ptr == $past(rd_ptr))
        else $error("coded_bit_fifo read while empty");

endmodule

`default_nettype wire

// ==== ofdm_tx_top.sv ====
// 802.11a legacy transmitter front end
// Frame memory to rate-1/2 coded bit pairs

`timescale 1ns/1ps
`default_nettype none

module ofdm_tx_top
    import ofdm_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic                  i_start,
    input  logic [SCRAM_W-1:0]    i_scram_seed,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    input  logic [MEM_DATA_W-1:0] i_mem_rdata,
    output logic                  o_coded_valid,
    output logic [1:0]            o_coded_bits,
    input  logic                  i_coded_ready,
    output logic                  o_done,
    output logic                  o_busy
);

    l_sig_u sig;

    tx_bit_if frame_bits ();
    coded_if  data_bits ();
    coded_if  coded_pairs ();

    frame_fetch u_fetch (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_start     (i_start),
        .i_done      (o_done),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_addr  (o_mem_addr),
        .o_busy      (o_busy),
        .o_sig       (sig),
        .bits_out    (frame_bits.src)
    );

    tx_bit_sequencer u_seq (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_scram_seed (i_scram_seed),
        .i_sig        (sig),
        .bits_in      (frame_bits.snk),
        .bits_out     (data_bits.src)
    );

    conv_encoder u_enc (
        .clk       (clk),
        .reset_int (reset_int),
        .bits_in   (data_bits.snk),
        .pairs_out (coded_pairs.src)
    );

    coded_bit_fifo u_fifo (
        .clk           (clk),
        .reset_int     (reset_int),
        .i_coded_ready (i_coded_ready),
        .pairs_in      (coded_pairs.snk),
        .o_coded_valid (o_coded_valid),
        .o_coded_bits  (o_coded_bits),
        .o_done        (o_done)
    );

endmodule

`default_nettype wire

// ==== tb_ref_model.svh ====
// Reference model for the transmitter testbench
// Builds the expected coded pair sequence of one frame

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Legacy OFDM carries four data bits per symbol for every Mbps
function automatic int dbps_for_rate(input logic [3:0] rate);
    int mbps;
    case (rate)
        4'b1011: mbps = 6;
        4'b1111: mbps = 9;
        4'b1010: mbps = 12;
        4'b1110: mbps = 18;
        4'b1001: mbps = 24;
        4'b1101: mbps = 36;
        4'b1000: mbps = 48;
        4'b1100: mbps = 54;
        default: mbps = 6;
    endcase
    return 4 * mbps;
endfunction

// Closed form of the pair count, L-SIG plus whole DATA symbols
function automatic int pair_count(input logic [3:0] rate, input int length);
    int dbps;
    int nbits;
    dbps  = dbps_for_rate(rate);
    nbits = SERVICE_BITS + 8 * length + TAIL_BITS;
    return SIG_BITS + ((nbits + dbps - 1) / dbps) * dbps;
endfunction

// Byte-wise IEEE CRC-32 of the PSDU, complemented
function automatic logic [31:0] fcs_of_psdu(input int n_bytes);
    logic [31:0] crc;
    int          i;
    int          b;
    crc = '1;
    for (i = 0; i < n_bytes; i++) begin
        crc = crc ^ {24'h0, psdu[i]};
        for (b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
        end
    end
    return ~crc;
endfunction

// Unscrambled DATA bit j: SERVICE, PSDU, FCS, then zeros for tail and pad
function automatic logic data_bit(input int j, input int n_bytes, input logic [31:0] fcs);
    int k;
    k = j - SERVICE_BITS;
    if (k < 0) begin
        return 1'b0;
    end
    if (k < 8 * n_bytes) begin
        return psdu[k / 8][k % 8];
    end
    k = k - 8 * n_bytes;
    if (k < FCS_BITS) begin
        return fcs[k];
    end
    return 1'b0;
endfunction

function automatic void build_expected(input l_sig_u sig, input logic [SCRAM_W-1:0] seed);
    int                 n_bytes;
    int                 n_data;
    int                 dbps;
    int                 tail_at;
    int                 p;
    int                 j;
    logic [31:0]        fcs;
    logic [SCRAM_W-1:0] scram;
    logic [5:0]         hist;
    logic [6:0]         taps;
    logic               b;
    logic               fb;
    n_bytes = int'(sig.f.length) - 4;
    dbps    = dbps_for_rate(sig.f.rate);
    fcs     = fcs_of_psdu(n_bytes);
    tail_at = SERVICE_BITS + 8 * int'(sig.f.length);
    n_data  = tail_at + TAIL_BITS;
    while (n_data % dbps != 0) begin
        n_data++;
    end
    exp_count = SIG_BITS + n_data;
    scram     = seed;
    hist      = '0;
    for (p = 0; p < exp_count; p++) begin
        // Encoder starts from zero at L-SIG and again at SERVICE
        if (p == 0 || p == SIG_BITS) begin
            hist = '0;
        end
        if (p < SIG_BITS) begin
            b = sig.raw[p];
        end else begin
            j     = p - SIG_BITS;
            fb    = scram[6] ^ scram[3];
            scram = {scram[5:0], fb};
            b     = data_bit(j, n_bytes, fcs);
            if (j < tail_at || j >= tail_at + TAIL_BITS) begin
                b = b ^ fb;
            end
        end
        taps        = {b, hist};
        exp_pair[p] = {^(taps & 7'o171), ^(taps & 7'o133)};
        hist        = taps[6:1];
    end
endfunction

`endif

// ==== tb_ofdm_tx.sv ====
// Testbench for the 802.11a transmitter front end
// Runs frames at several rates against a reference pair sequence,
// with random output back-pressure and a stray start inside a frame

`timescale 1ns/1ps
`default_nettype none

module tb_ofdm_tx
    import ofdm_tx_pkg::*;
();

    localparam int MAX_PAIRS  = 4096;
    localparam int MAX_BYTES  = 256;
    localparam int WAIT_LIMIT = 20000;

    logic                  clk = 1'b0;
    logic                  reset_int;
    logic                  i_start;
    logic [SCRAM_W-1:0]    i_scram_seed;
    logic [MEM_DATA_W-1:0] i_mem_rdata = '0;
    logic                  i_coded_ready = 1'b0;
    logic [MEM_ADDR_W-1:0] o_mem_addr;
    logic                  o_coded_valid;
    logic [1:0]            o_coded_bits;
    logic                  o_done;
    logic                  o_busy;

    logic [MEM_DATA_W-1:0] mem [1 << MEM_ADDR_W];
    logic [7:0]            psdu [MAX_BYTES];
    logic [1:0]            exp_pair [MAX_PAIRS];
    int                    exp_count = 0;
    int                    formula_count = 0;
    int                    addr_limit = 0;
    int                    error_count = 0;
    bit                    timed_out = 1'b0;
    bit                    random_ready = 1'b0;

    // Acceptance tracking, registered on each rising edge
    int                    acc_idx;
    logic                  acc;
    logic                  seen_start;
    logic                  start_idle_q;
    logic                  last_acc_q;
    logic                  hold_q;
    logic [1:0]            bits_q;
    logic [MEM_ADDR_W-1:0] rd_addr;

    `include "tb_ref_model.svh"

    always #20 clk = ~clk;

    ofdm_tx_top i_dut (
        .clk           (clk),
        .reset_int     (reset_int),
        .i_start       (i_start),
        .i_scram_seed  (i_scram_seed),
        .o_mem_addr    (o_mem_addr),
        .i_mem_rdata   (i_mem_rdata),
        .o_coded_valid (o_coded_valid),
        .o_coded_bits  (o_coded_bits),
        .i_coded_ready (i_coded_ready),
        .o_done        (o_done),
        .o_busy        (o_busy)
    );

    // Frame memory, data for an address one cycle later
    always @(posedge clk) begin
        rd_addr = o_mem_addr;
        #2;
        i_mem_rdata = mem[rd_addr];
    end

    always @(posedge clk) begin : ready_drive
        bit use_random;
        use_random = random_ready;
        #2;
        if (use_random) begin
            i_coded_ready = 1'($urandom);
        end else begin
            i_coded_ready = 1'b1;
        end
    end

    assign acc = o_coded_valid && i_coded_ready;

    always @(posedge clk) begin
        if (reset_int) begin
            acc_idx      <= 0;
            seen_start   <= 1'b0;
            start_idle_q <= 1'b0;
            last_acc_q   <= 1'b0;
            hold_q       <= 1'b0;
            bits_q       <= '0;
        end else begin
            if (i_start && !o_busy) begin
                acc_idx    <= 0;
                seen_start <= 1'b1;
            end else if (acc) begin
                acc_idx <= acc_idx + 1;
            end
            start_idle_q <= i_start && !o_busy && !o_done;
            last_acc_q   <= acc && acc_idx == exp_count - 1;
            hold_q       <= o_coded_valid && !i_coded_ready;
            bits_q       <= o_coded_bits;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset_int)
        !seen_start |-> {o_coded_valid, o_done, o_busy} == 3'b000)
        else begin
            $display("[ERROR] {o_coded_valid,o_done,o_busy} expected 0 actual %h",
                     $sampled({o_coded_valid, o_done, o_busy}));
            error_count++;
        end

    a_pair_value: assert property (@(posedge clk) disable iff (reset_int)
        (acc && acc_idx < exp_count) |-> o_coded_bits == exp_pair[acc_idx])
        else begin
            $display("[ERROR] o_coded_bits expected %h actual %h at pair %0d",
                     exp_pair[$sampled(acc_idx)], $sampled(o_coded_bits), $sampled(acc_idx));
            error_count++;
        end

    a_pair_overrun: assert property (@(posedge clk) disable iff (reset_int)
        acc |-> acc_idx < exp_count)
        else begin
            $display("[ERROR] pair index expected below %h actual %h",
                     exp_count, $sampled(acc_idx));
            error_count++;
        end

    // Done follows the last accepted pair by exactly one cycle
    a_done_timing: assert property (@(posedge clk) disable iff (reset_int)
        o_done == last_acc_q)
        else begin
            $display("[ERROR] o_done expected %h actual %h",
                     $sampled(last_acc_q), $sampled(o_done));
            error_count++;
        end

    a_done_count: assert property (@(posedge clk) disable iff (reset_int)
        o_done |-> acc_idx == formula_count)
        else begin
            $display("[ERROR] pair count at o_done expected %h actual %h",
                     formula_count, $sampled(acc_idx));
            error_count++;
        end

    a_busy_fall: assert property (@(posedge clk) disable iff (reset_int)
        o_done |-> !o_busy)
        else begin
            $display("[ERROR] o_busy expected 0 actual %h during o_done", $sampled(o_busy));
            error_count++;
        end

    a_busy_rise: assert property (@(posedge clk) disable iff (reset_int)
        start_idle_q |-> o_busy)
        else begin
            $display("[ERROR] o_busy expected 1 actual %h after start", $sampled(o_busy));
            error_count++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (reset_int)
        hold_q |-> (o_coded_valid && o_coded_bits == bits_q))
        else begin
            $display("[ERROR] o_coded_bits expected %h actual %h (valid %h) while stalled",
                     $sampled(bits_q), $sampled(o_coded_bits), $sampled(o_coded_valid));
            error_count++;
        end

    // Reads stay within the words that hold the PSDU
    a_addr_limit: assert property (@(posedge clk) disable iff (reset_int)
        o_busy |-> o_mem_addr <= addr_limit)
        else begin
            $display("[ERROR] o_mem_addr expected at most %h actual %h",
                     addr_limit, $sampled(o_mem_addr));
            error_count++;
        end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic fill_memory();
        int a;
        for (a = 0; a < (1 << MEM_ADDR_W); a++) begin
            mem[a] = {4'h5, 12'(a), 4'hC, ~12'(a), 4'h3, 12'(a), 4'h9, ~12'(a)};
        end
    endtask

    function automatic logic [SCRAM_W-1:0] pick_seed(input logic [SCRAM_W-1:0] avoid);
        logic [SCRAM_W-1:0] s;
        s = '0;
        while (s == '0 || s == avoid) begin
            s = SCRAM_W'($urandom);
        end
        return s;
    endfunction

    task automatic wait_for_done();
        int n;
        n = 0;
        while (!o_done && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!o_done) begin
            $display("Timeout: o_done did not pulse within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame(input logic [3:0] rate, input int length,
                             input logic [SCRAM_W-1:0] seed, input bit stray_start);
        l_sig_u sig;
        int     i;
        int     n;
        sig          = '0;
        sig.f.rate   = rate;
        sig.f.length = LEN_W'(length);
        sig.f.parity = ^sig.raw[16:0];
        mem[0]       = {mem[0][MEM_DATA_W-1:SIG_BITS], sig.raw};
        for (i = 0; i < length - 4; i++) begin
            psdu[i] = 8'($urandom);
            mem[1 + i / 8][8 * (i % 8) +: 8] = psdu[i];
        end
        build_expected(sig, seed);
        formula_count = pair_count(rate, length);
        // PSDU bytes fill eight per word from word 1
        addr_limit    = (length - 4 + 7) / 8;
        i_scram_seed  = seed;
        i_start       = 1'b1;
        @(posedge clk);
        #2;
        i_start = 1'b0;
        if (stray_start) begin
            n = 0;
            while (acc_idx < 40 && n < WAIT_LIMIT) begin
                @(posedge clk);
                #2;
                n++;
            end
            if (acc_idx < 40) begin
                $display("Timeout: the frame gave too few coded pairs in %0d cycles",
                         WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                i_start = 1'b1;
                @(posedge clk);
                #2;
                i_start = 1'b0;
            end
        end
        if (!timed_out) begin
            wait_for_done();
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    initial begin
        logic [SCRAM_W-1:0] seed;
        int                 len;
        int                 prev_len;
        void'($urandom(84348));
        reset_int    = 1'b1;
        i_start      = 1'b0;
        i_scram_seed = '0;
        fill_memory();
        repeat (3) @(posedge clk);
        #2;
        reset_int = 1'b0;
        // Idle stretch before the first start
        repeat (8) @(posedge clk);
        #2;

        seed = pick_seed('0);
        len  = 5 + int'($urandom % 40);
        run_frame(4'b1011, len, seed, 1'b0);
        random_ready = 1'b1;
        if (!timed_out) begin
            seed = pick_seed(seed);
            len  = 5 + int'($urandom % 40);
            run_frame(4'b1100, len, seed, 1'b0);
        end
        // Unknown rate code, with a start pulse in the middle of the frame
        if (!timed_out) begin
            seed     = pick_seed(seed);
            prev_len = 5 + int'($urandom % 40);
            run_frame(4'b0111, prev_len, seed, 1'b1);
        end
        if (!timed_out) begin
            seed = pick_seed(seed);
            len  = prev_len;
            while (len == prev_len) begin
                len = 5 + int'($urandom % 40);
            end
            run_frame(4'b1100, len, seed, 1'b0);
        end

        $display("Summary: %0d assertion errors, %0d timeouts", error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
ofdm_tx_pkg.sv
ofdm_tx_if.sv
frame_fetch.sv
crc32_fcs.sv
tx_bit_sequencer.sv
conv_encoder.sv
coded_bit_fifo.sv
ofdm_tx_top.sv
tb_ofdm_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the transmitter testbench with Verilator and runs it.
# The log decides the outcome.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_ofdm_tx -f vlog.f \
    && ./obj_dir/Vtb_ofdm_tx > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

[ -f sim.log ] && cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1
